/* include/loader_config.svh */
`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// number of array columns
// config tables are ordered control[0..NUM_COL-1], immediate[0..NUM_COL-1], state
`define NUM_COL 2

// table address width, also the width of the entry counts
`define ADDR_W 4

// one configuration word
`define DATA_W 32

// entries per table
`define TABLE_DEPTH (1 << `ADDR_W)

// word buffer slots
// the sender starts out with this many credits
`define BUF_DEPTH 4

// total config tables: control + immediate + state
`define NUM_CFG_TABLES (2 * `NUM_COL + 1)

`endif

/* hw/loader_types_pkg.sv */
`default_nettype none

`include "loader_config.svh"

package loader_types_pkg;

    // table address, also used for the entry counts
    typedef logic [`ADDR_W-1:0] addr_t;

    // configuration word as it arrives on the stream
    typedef logic [`DATA_W-1:0] data_t;

    // one-hot select over all config tables
    // bit 0 is the first control table, msb is the state table
    typedef logic [`NUM_CFG_TABLES-1:0] table_sel_t;

    // occupancy / credit count, must reach BUF_DEPTH itself
    typedef logic [$clog2(`BUF_DEPTH + 1)-1:0] credit_cnt_t;

endpackage

`default_nettype wire

/* hw/loader_ctrl_pkg.sv */
`default_nettype none

package loader_ctrl_pkg;

    // sequencer states
    // ARMED waits for the falling edge of start
    // DONE lasts exactly one cycle
    typedef enum logic [2:0] {
        IDLE,
        ARMED,
        LOAD_CONFIG,
        LOAD_INBOUND,
        DONE
    } load_state_t;

endpackage

`default_nettype wire

/* hw/load_word_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "loader_config.svh"

module load_word_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  loader_types_pkg::data_t in_data,
    input  logic                   pop,
    output loader_types_pkg::data_t head_data,
    output logic                   not_empty,
    output logic                   credit
);

    localparam int PTR_W = (`BUF_DEPTH > 1) ? $clog2(`BUF_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`BUF_DEPTH - 1);

    // word storage, no reset needed on payload
    loader_types_pkg::data_t mem [`BUF_DEPTH];

    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    loader_types_pkg::credit_cnt_t count;

    // sender only pushes with a credit in hand, so no full check here
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at the last slot, depth need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + PTR_W'(1);
            end
        end
    end

    // occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (in_valid && !pop) begin
            count <= count + loader_types_pkg::credit_cnt_t'(1);
        end else if (pop && !in_valid) begin
            count <= count - loader_types_pkg::credit_cnt_t'(1);
        end
    end

    // one credit back per popped word, one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            credit <= 1'b0;
        end else begin
            credit <= pop;
        end
    end

    // head word is visible while the slot is occupied
    assign head_data = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

`default_nettype wire

/* hw/load_addr_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module load_addr_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  loader_ctrl_pkg::load_state_t  state,
    input  logic                          advance,
    input  loader_types_pkg::addr_t       num_entry_config,
    input  loader_types_pkg::addr_t       num_entry_inbound,
    output loader_types_pkg::addr_t       addr,
    output loader_types_pkg::table_sel_t  table_sel,
    output logic                          phase_last
);

    localparam int MSB = $bits(loader_types_pkg::table_sel_t) - 1;

    loader_types_pkg::addr_t limit;
    logic                    table_end;
    logic                    in_config;

    assign in_config = (state == loader_ctrl_pkg::LOAD_CONFIG);

    // wrap point of the current phase
    assign limit = in_config ? num_entry_config : num_entry_inbound;

    // last entry of the current table
    assign table_end = (addr == limit - loader_types_pkg::addr_t'(1));

    // end of phase: last entry of the state table, or last inbound entry
    always_comb begin
        phase_last = 1'b0;
        if (in_config) begin
            phase_last = table_end && table_sel[MSB];
        end else if (state == loader_ctrl_pkg::LOAD_INBOUND) begin
            phase_last = table_end;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr      <= '0;
            table_sel <= '0;
        end else if (state == loader_ctrl_pkg::ARMED) begin
            // config phase opens on table 0
            addr      <= '0;
            table_sel <= loader_types_pkg::table_sel_t'(1);
        end else if (advance) begin
            if (phase_last) begin
                addr      <= '0;
                table_sel <= '0;
            end else if (table_end) begin
                // only reachable in config, move on to next table
                addr      <= '0;
                table_sel <= table_sel << 1;
            end else begin
                addr <= addr + loader_types_pkg::addr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/load_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module load_sequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          not_empty,
    input  logic                          phase_last,
    output loader_ctrl_pkg::load_state_t  state,
    output logic                          pop,
    output logic                          cfg_write,
    output logic                          inb_write,
    output logic                          done,
    output logic                          busy
);

    loader_ctrl_pkg::load_state_t next_state;

    logic loading;

    // words are only consumed in the two load phases
    assign loading = (state == loader_ctrl_pkg::LOAD_CONFIG) ||
                     (state == loader_ctrl_pkg::LOAD_INBOUND);

    // empty buffer simply stalls, nothing is written
    assign pop = loading && not_empty;

    // steer the popped word to one of the banks
    assign cfg_write = pop && (state == loader_ctrl_pkg::LOAD_CONFIG);
    assign inb_write = pop && (state == loader_ctrl_pkg::LOAD_INBOUND);

    // state register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= loader_ctrl_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            loader_ctrl_pkg::IDLE: begin
                // rising side of the start pulse
                if (start) begin
                    next_state = loader_ctrl_pkg::ARMED;
                end
            end
            loader_ctrl_pkg::ARMED: begin
                // load begins once start falls
                if (!start) begin
                    next_state = loader_ctrl_pkg::LOAD_CONFIG;
                end
            end
            loader_ctrl_pkg::LOAD_CONFIG: begin
                // last entry of the state table
                if (pop && phase_last) begin
                    next_state = loader_ctrl_pkg::LOAD_INBOUND;
                end
            end
            loader_ctrl_pkg::LOAD_INBOUND: begin
                if (pop && phase_last) begin
                    next_state = loader_ctrl_pkg::DONE;
                end
            end
            loader_ctrl_pkg::DONE: begin
                // single cycle, then back to idle
                next_state = loader_ctrl_pkg::IDLE;
            end
            default: begin
                next_state = loader_ctrl_pkg::IDLE;
            end
        endcase
    end

    // status outputs decoded from the state register
    assign done = (state == loader_ctrl_pkg::DONE);
    assign busy = (state != loader_ctrl_pkg::IDLE);

endmodule

`default_nettype wire

/* hw/table_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "loader_config.svh"

module table_bank #(
    parameter int NUM_TABLES = 1
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             wr,
    input  logic [NUM_TABLES-1:0]                            wr_sel,
    input  loader_types_pkg::addr_t                          wr_addr,
    input  loader_types_pkg::data_t                          wr_data,
    input  logic [((NUM_TABLES > 1) ? $clog2(NUM_TABLES) : 1)-1:0] rd_table,
    input  loader_types_pkg::addr_t                          rd_addr,
    output loader_types_pkg::data_t                          rd_data
);

    // one memory per table, all the same depth
    loader_types_pkg::data_t mem [NUM_TABLES][`TABLE_DEPTH];

    // tables start out cleared
    // wr_sel is one-hot, so at most one table takes the word
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < NUM_TABLES; t++) begin
                for (int a = 0; a < `TABLE_DEPTH; a++) begin
                    mem[t][a] <= '0;
                end
            end
        end else if (wr) begin
            for (int t = 0; t < NUM_TABLES; t++) begin
                if (wr_sel[t]) begin
                    mem[t][wr_addr] <= wr_data;
                end
            end
        end
    end

    // combinational read
    // an index past the last table reads as zero
    always_comb begin
        if (int'(rd_table) < NUM_TABLES) begin
            rd_data = mem[rd_table][rd_addr];
        end else begin
            rd_data = '0;
        end
    end

endmodule

`default_nettype wire

/* hw/runtime_loader.sv */
`timescale 1ns/1ns
`default_nettype none

`include "loader_config.svh"

module runtime_loader (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  loader_types_pkg::addr_t                num_entry_config,
    input  loader_types_pkg::addr_t                num_entry_inbound,
    input  logic                                   in_valid,
    input  loader_types_pkg::data_t                in_data,
    output logic                                   credit,
    output logic                                   done,
    output logic                                   busy,
    input  logic [$clog2(`NUM_CFG_TABLES)-1:0]     cfg_rd_table,
    input  loader_types_pkg::addr_t                cfg_rd_addr,
    output loader_types_pkg::data_t                cfg_rd_data,
    input  loader_types_pkg::addr_t                inb_rd_addr,
    output loader_types_pkg::data_t                inb_rd_data
);

    loader_types_pkg::data_t      head_data;
    logic                         not_empty;
    logic                         pop;
    logic                         cfg_write;
    logic                         inb_write;
    logic                         phase_last;
    loader_ctrl_pkg::load_state_t state;
    loader_types_pkg::addr_t      addr;
    loader_types_pkg::table_sel_t table_sel;

    // incoming word stream, credit based
    load_word_buffer u_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .pop       (pop),
        .head_data (head_data),
        .not_empty (not_empty),
        .credit    (credit)
    );

    // write address and table select, steps once per popped word
    load_addr_counter u_counter (
        .clk               (clk),
        .rst               (rst),
        .state             (state),
        .advance           (pop),
        .num_entry_config  (num_entry_config),
        .num_entry_inbound (num_entry_inbound),
        .addr              (addr),
        .table_sel         (table_sel),
        .phase_last        (phase_last)
    );

    load_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .not_empty  (not_empty),
        .phase_last (phase_last),
        .state      (state),
        .pop        (pop),
        .cfg_write  (cfg_write),
        .inb_write  (inb_write),
        .done       (done),
        .busy       (busy)
    );

    // control, immediate and state tables
    table_bank #(
        .NUM_TABLES (`NUM_CFG_TABLES)
    ) u_cfg_bank (
        .clk      (clk),
        .rst      (rst),
        .wr       (cfg_write),
        .wr_sel   (table_sel),
        .wr_addr  (addr),
        .wr_data  (head_data),
        .rd_table (cfg_rd_table),
        .rd_addr  (cfg_rd_addr),
        .rd_data  (cfg_rd_data)
    );

    // inbound data memory, a single always-selected table
    table_bank #(
        .NUM_TABLES (1)
    ) u_inb_bank (
        .clk      (clk),
        .rst      (rst),
        .wr       (inb_write),
        .wr_sel   (1'b1),
        .wr_addr  (addr),
        .wr_data  (head_data),
        .rd_table (1'b0),
        .rd_addr  (inb_rd_addr),
        .rd_data  (inb_rd_data)
    );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

// free running testbench clock
module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // starts low, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* tests/runtime_loader_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "loader_config.svh"

module runtime_loader_tb;

    localparam int NCFG  = `NUM_CFG_TABLES;
    localparam int SEL_W = $clog2(`NUM_CFG_TABLES);

    // entry counts of the two loads, second one smaller
    localparam int LOAD1_CFG = 12;
    localparam int LOAD1_INB = 14;
    localparam int LOAD2_CFG = 5;
    localparam int LOAD2_INB = 6;

    // run length budget
    localparam int TOTAL_WORDS     = NCFG * (LOAD1_CFG + LOAD2_CFG) + LOAD1_INB + LOAD2_INB;
    localparam int TIMEOUT_CYCLES  = 4 * TOTAL_WORDS + 200;

    logic                          clk;
    logic                          rst;
    logic                          start;
    loader_types_pkg::addr_t       num_entry_config;
    loader_types_pkg::addr_t       num_entry_inbound;
    logic                          in_valid;
    loader_types_pkg::data_t       in_data;
    logic                          credit;
    logic                          done;
    logic                          busy;
    logic [SEL_W-1:0]              cfg_rd_table;
    loader_types_pkg::addr_t       cfg_rd_addr;
    loader_types_pkg::data_t       cfg_rd_data;
    loader_types_pkg::addr_t       inb_rd_addr;
    loader_types_pkg::data_t       inb_rd_data;

    // words in stream order, sender walks through with tx_next
    loader_types_pkg::data_t       tx_words [$];
    int                            tx_next;
    int                            sent_count;
    int                            returned_count;
    // 3-bit counter, a drop below zero wraps above BUF_DEPTH
    loader_types_pkg::credit_cnt_t credits;
    logic                          in_load;
    int                            cycle_count;

    // expected table contents, zero after reset
    loader_types_pkg::data_t       exp_cfg [NCFG][`TABLE_DEPTH];
    loader_types_pkg::data_t       exp_inb [`TABLE_DEPTH];

    tb_clock #(
        .PERIOD_NS (4)
    ) u_clock (
        .clk (clk)
    );

    runtime_loader dut (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .num_entry_config  (num_entry_config),
        .num_entry_inbound (num_entry_inbound),
        .in_valid          (in_valid),
        .in_data           (in_data),
        .credit            (credit),
        .done              (done),
        .busy              (busy),
        .cfg_rd_table      (cfg_rd_table),
        .cfg_rd_addr       (cfg_rd_addr),
        .cfg_rd_data       (cfg_rd_data),
        .inb_rd_addr       (inb_rd_addr),
        .inb_rd_data       (inb_rd_data)
    );

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // done is a single cycle pulse
    done_single: assert property (@(posedge clk) disable iff (rst)
        !(done && $past(done)))
        else begin
            $display("done stayed high for more than one cycle");
            abort_run();
        end

    // every queued word is out before done
    done_after_words: assert property (@(posedge clk) disable iff (rst)
        done |-> (tx_next == tx_words.size()))
        else begin
            $display("FAIL tx_next=%h expected %h at done", tx_next, tx_words.size());
            abort_run();
        end

    // one credit back per word sent
    done_credits: assert property (@(posedge clk) disable iff (rst)
        done |-> (returned_count == sent_count))
        else begin
            $display("FAIL returned_count=%h expected %h", returned_count, sent_count);
            abort_run();
        end

    credit_bounds: assert property (@(posedge clk) disable iff (rst)
        credits <= loader_types_pkg::credit_cnt_t'(`BUF_DEPTH))
        else begin
            $display("FAIL credits=%h outside 0..%h", credits, `BUF_DEPTH);
            abort_run();
        end

    // loader quiet between loads
    idle_not_busy: assert property (@(posedge clk) disable iff (rst)
        !in_load |-> !busy)
        else begin
            $display("busy was high while no load was running");
            abort_run();
        end

    // busy only drops after done
    busy_holds: assert property (@(posedge clk) disable iff (rst)
        ($past(busy) && !$past(done)) |-> busy)
        else begin
            $display("busy fell before the load signalled done");
            abort_run();
        end

    start_arms: assert property (@(posedge clk) disable iff (rst)
        $past(start) |-> busy)
        else begin
            $display("busy did not rise while start was high");
            abort_run();
        end

    // nothing popped until start has fallen
    armed_no_credit: assert property (@(posedge clk) disable iff (rst)
        (start || $past(start)) |-> !credit)
        else begin
            $display("a credit came back while start was still high");
            abort_run();
        end

    // credit accounting and word sender
    initial begin
        in_valid       = 1'b0;
        in_data        = '0;
        tx_next        = 0;
        sent_count     = 0;
        returned_count = 0;
        credits        = loader_types_pkg::credit_cnt_t'(`BUF_DEPTH);
        forever begin
            @(posedge clk);
            #1;
            if (credit) begin
                credits        = credits + loader_types_pkg::credit_cnt_t'(1);
                returned_count = returned_count + 1;
            end
            in_valid = 1'b0;
            // random idle gaps, roughly one cycle in four
            if (!rst && tx_next < tx_words.size() && credits != '0 &&
                $urandom_range(3, 0) != 0) begin
                in_valid   = 1'b1;
                in_data    = tx_words[tx_next];
                tx_next    = tx_next + 1;
                credits    = credits - loader_types_pkg::credit_cnt_t'(1);
                sent_count = sent_count + 1;
            end
        end
    end

    // run limit
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
            if (cycle_count > TIMEOUT_CYCLES) begin
                $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
                abort_run();
            end
        end
    end

    // queue one load, pulse start and wait for done
    task automatic run_load(input int nc, input int ni);
        int                      cfg_words;
        int                      total;
        int                      hold;
        int                      k;
        loader_types_pkg::data_t w;
        cfg_words = NCFG * nc;
        total     = cfg_words + ni;
        @(negedge clk);
        // word k goes to table k / nc, entry k % nc, then inbound in order
        for (k = 0; k < total; k++) begin
            w = loader_types_pkg::data_t'($urandom);
            tx_words.push_back(w);
            if (k < cfg_words) begin
                exp_cfg[k / nc][k % nc] = w;
            end else begin
                exp_inb[k - cfg_words] = w;
            end
        end
        hold = $urandom_range(4, 2);
        @(posedge clk);
        #1;
        num_entry_config  = loader_types_pkg::addr_t'(nc);
        num_entry_inbound = loader_types_pkg::addr_t'(ni);
        start             = 1'b1;
        in_load           = 1'b1;
        // start held for a few cycles, load waits for its fall
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        start = 1'b0;
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        // loader back in idle one edge later
        @(posedge clk);
        #1;
        in_load = 1'b0;
    endtask

    // read every entry of every table through the read ports
    task automatic check_tables();
        int t;
        int a;
        for (t = 0; t < NCFG; t++) begin
            for (a = 0; a < `TABLE_DEPTH; a++) begin
                @(posedge clk);
                #1;
                cfg_rd_table = SEL_W'(t);
                cfg_rd_addr  = loader_types_pkg::addr_t'(a);
                @(negedge clk);
                assert (cfg_rd_data == exp_cfg[t][a])
                    else begin
                        $display("FAIL cfg_rd_data table %h addr %h: got %h expected %h",
                                 t, a, cfg_rd_data, exp_cfg[t][a]);
                        abort_run();
                    end
            end
        end
        for (a = 0; a < `TABLE_DEPTH; a++) begin
            @(posedge clk);
            #1;
            inb_rd_addr = loader_types_pkg::addr_t'(a);
            @(negedge clk);
            assert (inb_rd_data == exp_inb[a])
                else begin
                    $display("FAIL inb_rd_data addr %h: got %h expected %h",
                             a, inb_rd_data, exp_inb[a]);
                    abort_run();
                end
        end
    endtask

    initial begin
        void'($urandom(32'h4939388d));
        rst               = 1'b1;
        start             = 1'b0;
        num_entry_config  = '0;
        num_entry_inbound = '0;
        cfg_rd_table      = '0;
        cfg_rd_addr       = '0;
        inb_rd_addr       = '0;
        in_load           = 1'b0;
        for (int t = 0; t < NCFG; t++) begin
            for (int a = 0; a < `TABLE_DEPTH; a++) begin
                exp_cfg[t][a] = '0;
            end
        end
        for (int a = 0; a < `TABLE_DEPTH; a++) begin
            exp_inb[a] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        run_load(LOAD1_CFG, LOAD1_INB);
        check_tables();
        // smaller counts, upper entries keep the first load
        run_load(LOAD2_CFG, LOAD2_INB);
        check_tables();

        if (tx_next == tx_words.size() && returned_count == sent_count &&
            credits == loader_types_pkg::credit_cnt_t'(`BUF_DEPTH)) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("words or credits still outstanding at the end of the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hw/loader_types_pkg.sv
hw/loader_ctrl_pkg.sv
hw/load_word_buffer.sv
hw/load_addr_counter.sv
hw/load_sequencer.sv
hw/table_bank.sv
hw/runtime_loader.sv
tests/tb_clock.sv
tests/runtime_loader_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the runtime loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module runtime_loader_tb \
    -f list.f \
    -o runtime_loader_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/runtime_loader_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
